// ==== src/vlc_defs.svh ====
`ifndef VLC_DEFS_SVH
`define VLC_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Stream location in SRAM

`define STREAM_BASE 18'd76800

// Header marker words
`define MARK_HI 16'hDEAD
`define MARK_LO 16'hBEEF

//////////////////////////////////////////////////////////////////////
// Widths

`define WORD_W 16
`define ADDR_W 18
`define WIN_W 48

// Scan index of the final coefficient in a block
`define BLK_LAST 6'd63

`endif

// ==== src/vlc_pkg.sv ====
package vlc_pkg;

	// Meaning of one decoded symbol
	typedef enum logic [1:0] {
		SYM_VALUE,  // One value, 3, 6 or 9 bits
		SYM_PAIR,   // Two 3-bit values
		SYM_RUN,    // Zero run of 1 to 8
		SYM_EOB     // Zeros to end of block
	} sym_kind_e;

	// Header search and window fill
	typedef enum logic [2:0] {
		IDLE,
		FIND_HI,
		FIND_LO,
		READ_Q,
		SKIP_SIZE,
		PRIME,
		STREAM
	} fetch_state_e;

	typedef logic signed [31:0] coeff_t;

	// Raw value before dequantization
	typedef logic signed [8:0] raw_val_t;

endpackage

// ==== src/stream_fetch.sv ====
`timescale 1ns/1ps

`include "vlc_defs.svh"

module stream_fetch (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start_req,
	output logic [`ADDR_W-1:0] sram_address,
	input logic [`WORD_W-1:0] sram_read_data,
	output logic [`WIN_W-1:0] window,
	output logic win_valid,
	input logic consume,
	input logic [3:0] consume_len,
	output logic q_select
);

vlc_pkg::fetch_state_e state;

logic [`ADDR_W-1:0] rd_ptr;
logic addr_live;            // sram_address holds a real request
logic [1:0] tag_pipe;
logic [1:0] in_flight;
logic [5:0] bit_count;
logic [6:0] fill_level;
logic issue;
logic data_valid;
logic merge;
logic [3:0] shift_len;
logic [5:0] count_after;
logic [`WIN_W-1:0] shifted;
logic [`WIN_W-1:0] placed;

assign data_valid = tag_pipe[1];  // Word for the address of two cycles back
assign win_valid = (bit_count >= 6'd32);

assign in_flight = {1'b0, addr_live} + {1'b0, tag_pipe[0]} + {1'b0, tag_pipe[1]};
assign fill_level = {1'b0, bit_count} + {1'b0, in_flight, 4'd0};

assign merge = data_valid && (state == vlc_pkg::PRIME || state == vlc_pkg::STREAM);

always_comb begin
	case (state)
		vlc_pkg::IDLE: issue = start_req;
		vlc_pkg::FIND_HI,
		vlc_pkg::FIND_LO,
		vlc_pkg::READ_Q,
		vlc_pkg::SKIP_SIZE: issue = 1'b1;
		vlc_pkg::STREAM: issue = (fill_level <= 7'd32);  // Room for one more word
		default: issue = 1'b0;
	endcase
end

// Consume first, then the new word lands right after the remaining bits
always_comb begin
	shift_len = consume ? consume_len : 4'd0;
	count_after = bit_count - {2'b00, shift_len};
	shifted = window << shift_len;
	placed = {sram_read_data, {(`WIN_W-`WORD_W){1'b0}}} >> count_after;
end

always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
	if (!Resetn) begin
		state <= vlc_pkg::IDLE;
		rd_ptr <= `STREAM_BASE;
		sram_address <= `STREAM_BASE;
		addr_live <= 1'b0;
		tag_pipe <= 2'b00;
		bit_count <= 6'd0;
		window <= '0;
		q_select <= 1'b0;
	end else begin
		addr_live <= issue;
		tag_pipe <= {tag_pipe[0], addr_live};
		if (issue) begin
			sram_address <= rd_ptr;
			rd_ptr <= rd_ptr + 1'b1;
		end

		window <= merge ? (shifted | placed) : shifted;
		bit_count <= merge ? count_after + 6'd16 : count_after;

		case (state)
			vlc_pkg::IDLE: begin
				if (start_req)
					state <= vlc_pkg::FIND_HI;
			end
			vlc_pkg::FIND_HI: begin
				if (data_valid && sram_read_data == `MARK_HI)
					state <= vlc_pkg::FIND_LO;
			end
			vlc_pkg::FIND_LO: begin
				if (data_valid) begin
					if (sram_read_data == `MARK_LO)
						state <= vlc_pkg::READ_Q;
					else if (sram_read_data != `MARK_HI)  // DEAD DEAD BEEF still matches
						state <= vlc_pkg::FIND_HI;
				end
			end
			vlc_pkg::READ_Q: begin
				// Third word has the table bit over the width
				if (data_valid) begin
					q_select <= sram_read_data[15];
					state <= vlc_pkg::SKIP_SIZE;
				end
			end
			vlc_pkg::SKIP_SIZE: begin
				// Height word, reads already in flight belong to the stream
				if (data_valid)
					state <= vlc_pkg::PRIME;
			end
			vlc_pkg::PRIME: begin
				if (win_valid)
					state <= vlc_pkg::STREAM;
			end
			vlc_pkg::STREAM: begin
				state <= vlc_pkg::STREAM;
			end
			default: state <= vlc_pkg::IDLE;
		endcase
	end
end

// Decoder never takes more bits than the window holds
assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
	consume |-> ({2'b00, consume_len} <= bit_count));

endmodule

// ==== src/symbol_decoder.sv ====
`timescale 1ns/1ps

`include "vlc_defs.svh"

module symbol_decoder (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic [`WIN_W-1:0] window,
	input logic win_valid,
	input logic block_active,
	output logic consume,
	output logic [3:0] consume_len,
	output logic sym_valid,
	input logic sym_ready,
	output vlc_pkg::sym_kind_e sym_kind,
	output vlc_pkg::raw_val_t sym_val_a,
	output vlc_pkg::raw_val_t sym_val_b,
	output logic [3:0] sym_run
);

logic [12:0] top;   // Longest code is 13 bits
logic stall_q;

assign top = window[`WIN_W-1 -: 13];

assign sym_valid = win_valid & block_active;
assign consume = sym_valid & sym_ready;

//////////////////////////////////////////////////////////////////////
// Prefix decode

always_comb begin
	sym_kind = vlc_pkg::SYM_VALUE;
	sym_val_a = '0;
	sym_val_b = '0;
	sym_run = 4'd0;
	consume_len = 4'd0;
	case (top[12:11])
		2'b00: begin
			sym_kind = vlc_pkg::SYM_PAIR;
			sym_val_a = {{6{top[10]}}, top[10:8]};
			sym_val_b = {{6{top[7]}}, top[7:5]};
			consume_len = 4'd8;
		end
		2'b01: begin
			sym_val_a = {{6{top[10]}}, top[10:8]};
			consume_len = 4'd5;
		end
		2'b10: begin
			if (!top[10]) begin
				// 100 plus six bits
				sym_val_a = {{3{top[9]}}, top[9:4]};
				consume_len = 4'd9;
			end else if (top[9]) begin
				sym_val_a = top[8:0];  // 1011 plus nine bits
				consume_len = 4'd13;
			end else begin
				sym_kind = vlc_pkg::SYM_EOB;
				consume_len = 4'd4;
			end
		end
		default: begin
			sym_kind = vlc_pkg::SYM_RUN;
			sym_run = (top[10:8] == 3'd0) ? 4'd8 : {1'b0, top[10:8]};  // Count 0 means 8
			consume_len = 4'd5;
		end
	endcase
end

// Stall seen in the previous cycle
always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
	if (!Resetn)
		stall_q <= 1'b0;
	else
		stall_q <= sym_valid & ~sym_ready;
end

// A stalled symbol stays put until the writer takes it
assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
	stall_q && block_active |-> sym_valid && $stable(sym_kind) && $stable(sym_val_a)
		&& $stable(sym_val_b) && $stable(sym_run));

endmodule

// ==== src/zigzag_scan.sv ====
`timescale 1ns/1ps

`include "vlc_defs.svh"

module zigzag_scan (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic q_select,
	input logic step,
	input logic block_start,
	output logic [5:0] position,
	output logic [2:0] q_shift,
	output logic last
);

// Raster position for each scan index
localparam logic [5:0] zz_order [64] = '{
	6'd0,  6'd1,  6'd8,  6'd16, 6'd9,  6'd2,  6'd3,  6'd10,
	6'd17, 6'd24, 6'd32, 6'd25, 6'd18, 6'd11, 6'd4,  6'd5,
	6'd12, 6'd19, 6'd26, 6'd33, 6'd40, 6'd48, 6'd41, 6'd34,
	6'd27, 6'd20, 6'd13, 6'd6,  6'd7,  6'd14, 6'd21, 6'd28,
	6'd35, 6'd42, 6'd49, 6'd56, 6'd57, 6'd50, 6'd43, 6'd36,
	6'd29, 6'd22, 6'd15, 6'd23, 6'd30, 6'd37, 6'd44, 6'd51,
	6'd58, 6'd59, 6'd52, 6'd45, 6'd38, 6'd31, 6'd39, 6'd46,
	6'd53, 6'd60, 6'd61, 6'd54, 6'd47, 6'd55, 6'd62, 6'd63
};

// Shift per diagonal, last entry is never reached
localparam logic [2:0] q0_shift [16] = '{
	3'd3, 3'd2, 3'd3, 3'd3, 3'd4, 3'd4, 3'd5, 3'd5,
	3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd6, 3'd0
};

localparam logic [2:0] q1_shift [16] = '{
	3'd3, 3'd1, 3'd1, 3'd1, 3'd2, 3'd2, 3'd3, 3'd3,
	3'd4, 3'd4, 3'd4, 3'd5, 3'd5, 3'd5, 3'd5, 3'd0
};

logic [5:0] scan_index;
logic [3:0] diagonal;

assign position = zz_order[scan_index];
assign diagonal = {1'b0, position[5:3]} + {1'b0, position[2:0]};  // Row plus column
assign q_shift = q_select ? q1_shift[diagonal] : q0_shift[diagonal];
assign last = (scan_index == `BLK_LAST);

always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
	if (!Resetn) begin
		scan_index <= 6'd0;
	end else begin
		if (block_start)
			scan_index <= 6'd0;
		else if (step)
			scan_index <= scan_index + 6'd1;
	end
end

// Index holds at 63 until the next block clears it
assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
	!(step && last && !block_start));

endmodule

// ==== src/coeff_writer.sv ====
`timescale 1ns/1ps

module coeff_writer (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start_req,
	output logic done_ack,
	output logic block_active,
	input logic sym_valid,
	output logic sym_ready,
	input vlc_pkg::sym_kind_e sym_kind,
	input vlc_pkg::raw_val_t sym_val_a,
	input vlc_pkg::raw_val_t sym_val_b,
	input logic [3:0] sym_run,
	input logic [5:0] position,
	input logic [2:0] q_shift,
	input logic last,
	output logic step,
	output logic block_start,
	output logic coeff_we,
	output logic [5:0] coeff_address,
	output vlc_pkg::coeff_t coeff_data
);

logic end_q;        // Final write went out last cycle
logic pair_phase;   // Second half of a pair
logic [3:0] run_cnt;
logic eob_fill;
logic write_now;
logic take_sym;
vlc_pkg::raw_val_t write_value;
vlc_pkg::coeff_t wide_val;

assign block_start = start_req & ~block_active & ~done_ack & ~end_q;
assign step = write_now & ~last;
assign take_sym = block_active & sym_valid & ~eob_fill;
assign wide_val = write_value;  // Sign extends

//////////////////////////////////////////////////////////////////////
// One write per cycle, sym_ready only on the final cycle of a symbol

always_comb begin
	write_now = 1'b0;
	sym_ready = 1'b0;
	write_value = '0;
	if (block_active && eob_fill) begin
		write_now = 1'b1;
	end else if (take_sym) begin
		write_now = 1'b1;
		case (sym_kind)
			vlc_pkg::SYM_VALUE: begin
				write_value = sym_val_a;
				sym_ready = 1'b1;
			end
			vlc_pkg::SYM_PAIR: begin
				write_value = pair_phase ? sym_val_b : sym_val_a;
				sym_ready = pair_phase | last;  // Drop second half past 63
			end
			vlc_pkg::SYM_RUN: begin
				sym_ready = (run_cnt + 4'd1 == sym_run) | last;
			end
			default: sym_ready = 1'b1;
		endcase
	end
end

always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
	if (!Resetn) begin
		done_ack <= 1'b0;
		block_active <= 1'b0;
		end_q <= 1'b0;
		pair_phase <= 1'b0;
		run_cnt <= 4'd0;
		eob_fill <= 1'b0;
		coeff_we <= 1'b0;
	end else begin
		coeff_we <= write_now;
		end_q <= 1'b0;

		if (block_start)
			block_active <= 1'b1;
		if (write_now && last) begin
			block_active <= 1'b0;
			end_q <= 1'b1;
		end

		// Four-phase ack
		if (end_q)
			done_ack <= 1'b1;
		else if (done_ack && !start_req)
			done_ack <= 1'b0;

		if (take_sym && sym_kind == vlc_pkg::SYM_PAIR)
			pair_phase <= ~pair_phase & ~last;
		if (take_sym && sym_kind == vlc_pkg::SYM_RUN)
			run_cnt <= sym_ready ? 4'd0 : run_cnt + 4'd1;

		if (block_active && eob_fill)
			eob_fill <= ~last;
		else if (take_sym && sym_kind == vlc_pkg::SYM_EOB)
			eob_fill <= ~last;
	end
end

// Write port
always_ff @(posedge CLOCK_50_I) begin
	if (write_now) begin
		coeff_address <= position;
		coeff_data <= wide_val <<< q_shift;
	end
end

endmodule

// ==== src/block_decoder.sv ====
`timescale 1ns/1ps

`include "vlc_defs.svh"

module block_decoder (
	input logic CLOCK_50_I,
	input logic Resetn,
	input logic start_req,
	output logic done_ack,
	output logic [`ADDR_W-1:0] sram_address,
	input logic [`WORD_W-1:0] sram_read_data,
	output logic coeff_we,
	output logic [5:0] coeff_address,
	output vlc_pkg::coeff_t coeff_data
);

logic [`WIN_W-1:0] window;
logic win_valid;
logic consume;
logic [3:0] consume_len;
logic q_select;
logic block_active;
logic sym_valid;
logic sym_ready;
vlc_pkg::sym_kind_e sym_kind;
vlc_pkg::raw_val_t sym_val_a;
vlc_pkg::raw_val_t sym_val_b;
logic [3:0] sym_run;
logic [5:0] position;
logic [2:0] q_shift;
logic last;
logic step;
logic block_start;

stream_fetch fetch0 (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.start_req(start_req),
	.sram_address(sram_address),
	.sram_read_data(sram_read_data),
	.window(window),
	.win_valid(win_valid),
	.consume(consume),
	.consume_len(consume_len),
	.q_select(q_select)
);

symbol_decoder sym0 (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.window(window),
	.win_valid(win_valid),
	.block_active(block_active),
	.consume(consume),
	.consume_len(consume_len),
	.sym_valid(sym_valid),
	.sym_ready(sym_ready),
	.sym_kind(sym_kind),
	.sym_val_a(sym_val_a),
	.sym_val_b(sym_val_b),
	.sym_run(sym_run)
);

zigzag_scan scan0 (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.q_select(q_select),
	.step(step),
	.block_start(block_start),
	.position(position),
	.q_shift(q_shift),
	.last(last)
);

coeff_writer writer0 (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.start_req(start_req),
	.done_ack(done_ack),
	.block_active(block_active),
	.sym_valid(sym_valid),
	.sym_ready(sym_ready),
	.sym_kind(sym_kind),
	.sym_val_a(sym_val_a),
	.sym_val_b(sym_val_b),
	.sym_run(sym_run),
	.position(position),
	.q_shift(q_shift),
	.last(last),
	.step(step),
	.block_start(block_start),
	.coeff_we(coeff_we),
	.coeff_address(coeff_address),
	.coeff_data(coeff_data)
);

endmodule

// ==== tests/tb_tasks.svh ====
// Stream under construction
logic [`WORD_W-1:0] hdr_words [$];
bit code_bits [$];
int ref_blk;
int ref_idx;
logic ref_q;
int zz_ref [64];
vlc_pkg::coeff_t exp_coeff [4][64];

// Shift per diagonal for each table
localparam int shift_q0 [15] = '{3, 2, 3, 3, 4, 4, 5, 5, 6, 6, 6, 6, 6, 6, 6};
localparam int shift_q1 [15] = '{3, 1, 1, 1, 2, 2, 3, 3, 4, 4, 4, 5, 5, 5, 5};

function automatic void build_zigzag();
	int k;
	int r;
	int c;
	k = 0;
	for (int d = 0; d < 15; d++) begin
		for (int i = 0; i < 8; i++) begin
			r = (d % 2 == 1) ? i : 7 - i;  // Odd diagonals walk down
			c = d - r;
			if (c >= 0 && c < 8) begin
				zz_ref[k] = r * 8 + c;
				k++;
			end
		end
	end
endfunction

function automatic logic [15:0] fill_word(input logic [31:0] a);
	return a[15:0] ^ {a[1:0], a[17:4]};
endfunction

task automatic new_stream(input logic q, input int noise);
	logic [15:0] w;
	hdr_words.delete();
	code_bits.delete();
	ref_blk = -1;
	ref_q = q;
	repeat (noise) begin
		w = 16'($urandom);
		if (w == `MARK_HI || w == `MARK_LO)
			w = 16'h1234;
		hdr_words.push_back(w);
	end
	hdr_words.push_back(`MARK_HI);
	hdr_words.push_back(`MARK_LO);
	hdr_words.push_back({q, 15'($urandom)});  // Width word with table bit
	hdr_words.push_back(16'($urandom));       // Height
endtask

function automatic void new_block();
	ref_blk++;
	ref_idx = 0;
	for (int p = 0; p < 64; p++)
		exp_coeff[ref_blk][p] = '0;
endfunction

function automatic void put_bits(input logic [31:0] value, input int n);
	for (int i = n - 1; i >= 0; i--)
		code_bits.push_back(value[i]);
endfunction

// Reference write at the next scan index, nothing past 63
function automatic void ref_write(input int v);
	int pos;
	int d;
	int sh;
	if (ref_idx < 64) begin
		pos = zz_ref[ref_idx];
		d = pos / 8 + pos % 8;
		sh = ref_q ? shift_q1[d] : shift_q0[d];
		exp_coeff[ref_blk][pos] = vlc_pkg::coeff_t'(v) * (1 << sh);
		ref_idx++;
	end
endfunction

function automatic void put_pair(input int a, input int b);
	put_bits(0, 2);
	put_bits(a, 3);
	put_bits(b, 3);
	ref_write(a);
	ref_write(b);
endfunction

function automatic void put_value3(input int v);
	put_bits(1, 2);
	put_bits(v, 3);
	ref_write(v);
endfunction

function automatic void put_value6(input int v);
	put_bits(4, 3);
	put_bits(v, 6);
	ref_write(v);
endfunction

function automatic void put_value9(input int v);
	put_bits(11, 4);
	put_bits(v, 9);
	ref_write(v);
endfunction

function automatic void put_run(input int c);
	put_bits(3, 2);
	put_bits(c, 3);
	repeat ((c == 0) ? 8 : c) ref_write(0);
endfunction

function automatic void put_eob();
	put_bits(10, 4);
	while (ref_idx < 64)
		ref_write(0);
endfunction

task automatic load_sram();
	logic [31:0] a;
	logic [15:0] w;
	for (a = 0; a < (1 << `ADDR_W); a++)
		sram[a] = fill_word(a);
	a = `STREAM_BASE;
	foreach (hdr_words[i]) begin
		sram[a] = hdr_words[i];
		a++;
	end
	while (code_bits.size() % 16 != 0)
		code_bits.push_back(1'b0);
	for (int i = 0; i < code_bits.size(); i += 16) begin
		for (int j = 0; j < 16; j++)
			w[15 - j] = code_bits[i + j];
		sram[a] = w;
		a++;
	end
endtask

task automatic check_coeff(input string name, input vlc_pkg::coeff_t got,
		input vlc_pkg::coeff_t want);
	if (got !== want) begin
		$display("Mismatch %s: got %h, expected %h", name, got, want);
		mismatch_errors++;
	end
endtask

task automatic check_bit(input string name, input logic got, input logic want);
	if (got !== want) begin
		$display("Mismatch %s: got %h, expected %h", name, got, want);
		mismatch_errors++;
	end
endtask

task automatic wait_ack(input logic level, output bit ok);
	int n;
	ok = 1'b0;
	n = 0;
	while (!ok && n < 2000) begin
		@(negedge CLOCK_50_I);
		ok = (done_ack === level);
		n++;
	end
endtask

//////////////////////////////////////////////////////////////////////
// One four-phase transfer, then the block buffer against the reference

task automatic decode_block(input int blk, input int hold);
	bit ok;
	for (int p = 0; p < 64; p++) begin
		got_coeff[p] = 'x;
		wr_count[p] = 0;
	end
	@(negedge CLOCK_50_I);
	idle = 1'b0;
	start_req = 1'b1;
	wait_ack(1'b1, ok);
	if (!ok) begin
		$display("Timeout waiting for done_ack to rise on block %0d", blk);
		other_errors++;
	end
	idle = 1'b1;
	repeat (hold) begin
		@(negedge CLOCK_50_I);
		check_bit("done_ack", done_ack, 1'b1);
	end
	start_req = 1'b0;
	wait_ack(1'b0, ok);
	if (!ok) begin
		$display("Timeout waiting for done_ack to fall on block %0d", blk);
		other_errors++;
	end
	for (int p = 0; p < 64; p++) begin
		check_bit($sformatf("single write at position %0d", p), wr_count[p] == 1, 1'b1);
		check_coeff($sformatf("coeff_data at position %0d", p), got_coeff[p],
			exp_coeff[blk][p]);
	end
endtask

task automatic table0_block();
	apply_reset();
	new_stream(1'b0, 3 + $urandom_range(0, 4));
	new_block();
	repeat ($urandom_range(10, 30)) put_value3(int'($urandom_range(0, 7)) - 4);
	put_eob();
	load_sram();
	decode_block(0, 1);
endtask

task automatic table1_signed_block();
	apply_reset();
	new_stream(1'b1, 0);
	new_block();
	put_pair(-4, 3);
	put_value6(-32);
	put_value9(-256);
	put_pair(-1, 1);
	put_value9(255);
	put_value6(31);
	put_value6(-7);
	repeat (6) put_value9(int'($urandom_range(0, 511)) - 256);
	put_pair(2, -3);
	put_eob();
	load_sram();
	decode_block(0, 2);
endtask

task automatic zero_run_blocks();
	apply_reset();
	new_stream(1'b0, 1);
	new_block();
	put_value6(17);
	put_run(1);
	put_value3(-2);
	put_run(5);
	put_value9(-100);
	put_run(0);
	put_value3(3);
	put_run(3);
	put_eob();
	new_block();
	repeat (7) put_run(0);
	put_value3(1);
	put_run(0);   // Only 7 left in the block
	load_sram();
	decode_block(0, 1);
	decode_block(1, 1);
endtask

task automatic back_to_back_blocks();
	apply_reset();
	new_stream(1'b1, 2);
	new_block();
	repeat (4) put_value3(int'($urandom_range(0, 7)) - 4);
	put_eob();    // 24 bits, next code spans two words
	new_block();
	put_value9(-129);
	put_pair(1, -1);
	put_value3(-4);
	put_eob();
	load_sram();
	decode_block(0, 1);
	decode_block(1, 1);
endtask

task automatic handshake_sequence();
	apply_reset();
	check_bit("done_ack", done_ack, 1'b0);
	repeat (10) @(negedge CLOCK_50_I);
	new_stream(1'b0, 2);
	new_block();
	put_pair(1, 2);
	put_value6(-9);
	put_eob();
	new_block();
	put_run(4);
	put_value3(-1);
	put_eob();
	load_sram();
	decode_block(0, $urandom_range(1, 8));
	repeat ($urandom_range(1, 5)) @(negedge CLOCK_50_I);
	decode_block(1, $urandom_range(1, 8));
endtask

// ==== tests/tb_block_decoder.sv ====
`timescale 1ns/1ps

`include "vlc_defs.svh"

module tb_block_decoder;

logic CLOCK_50_I;
logic Resetn;
logic start_req;
logic done_ack;
logic [`ADDR_W-1:0] sram_address;
logic [`WORD_W-1:0] sram_read_data = '0;
logic coeff_we;
logic [5:0] coeff_address;
vlc_pkg::coeff_t coeff_data;

logic [`WORD_W-1:0] sram [0:(1 << `ADDR_W)-1];
logic [`WORD_W-1:0] rd_stage1 = '0;
logic [`WORD_W-1:0] rd_stage2 = '0;

// Block buffer as seen on the write port
vlc_pkg::coeff_t got_coeff [64];
int wr_count [64];
bit idle;           // No block in progress

int mismatch_errors;
int other_errors;

task automatic apply_reset();
	@(negedge CLOCK_50_I);
	Resetn = 1'b0;
	start_req = 1'b0;
	repeat (3) @(negedge CLOCK_50_I);
	Resetn = 1'b1;
	idle = 1'b1;
endtask

`include "tb_tasks.svh"

block_decoder dut0 (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.start_req(start_req),
	.done_ack(done_ack),
	.sram_address(sram_address),
	.sram_read_data(sram_read_data),
	.coeff_we(coeff_we),
	.coeff_address(coeff_address),
	.coeff_data(coeff_data)
);

initial begin
	CLOCK_50_I = 1'b0;
	forever #4 CLOCK_50_I = ~CLOCK_50_I;
end

//////////////////////////////////////////////////////////////////////
// SRAM model, data for an address shows up two cycles later

always @(negedge CLOCK_50_I) begin
	sram_read_data <= rd_stage2;
	rd_stage2 <= rd_stage1;
	rd_stage1 <= sram[sram_address];
end

// Write monitor
always @(negedge CLOCK_50_I) begin
	if (coeff_we === 1'b1) begin
		if (idle) begin
			$display("coeff_we went high while the decoder was idle at %0t", $time);
			other_errors++;
		end
		got_coeff[coeff_address] = coeff_data;
		wr_count[coeff_address]++;
	end
end

//////////////////////////////////////////////////////////////////////
// Test sequence

initial begin
	Resetn = 1'b0;
	start_req = 1'b0;
	idle = 1'b1;
	mismatch_errors = 0;
	other_errors = 0;
	void'($urandom(32'h6e89));
	build_zigzag();

	table0_block();
	table1_signed_block();
	zero_run_blocks();
	back_to_back_blocks();
	handshake_sequence();

	$display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
	if (mismatch_errors == 0 && other_errors == 0)
		$display("** PASS **");
	else
		$display("** FAIL **");
	$finish;
end

endmodule

// ==== list.f ====
+incdir+src
+incdir+tests
src/vlc_pkg.sv
src/stream_fetch.sv
src/symbol_decoder.sv
src/zigzag_scan.sv
src/coeff_writer.sv
src/block_decoder.sv
tests/tb_block_decoder.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the block decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module tb_block_decoder -o tb_block_decoder > build.log 2>&1 \
	&& ./obj_dir/tb_block_decoder > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q '\*\* FAIL \*\*' sim.log && exit 1 || exit 0
